/* logic/jtag_pkg.sv */
package jtag_pkg;

    localparam int INBOUND_DATA_WIDTH   = 8;
    localparam int UPSTREAM_BYPASS_BITS = 1;   // One device ahead of us in bypass
    localparam int RESULT_WIDTH         = 129;

    // One deserialized byte with its ready pulse
    typedef struct packed {
        logic                          strobe;
        logic [INBOUND_DATA_WIDTH-1:0] data;
    } inbound_t;

    // Found flag sits in the LSB so it leaves the shift register first
    typedef struct packed {
        logic [RESULT_WIDTH-2:0] digest;
        logic                    found;
    } result_t;

endpackage

/* logic/md5_pkg.sv */
package md5_pkg;

    localparam int MD5_BLOCK_LENGTH = 64;   // Bytes
    localparam int MAX_KEY_CHARS    = 12;
    localparam int SUFFIX_DIGITS    = 7;
    localparam int MAX_MSG_LENGTH   = 55;   // Leaves room for 0x80 and the length

    // Built as bytes, consumed as little-endian words
    typedef union packed {
        logic [MD5_BLOCK_LENGTH-1:0][7:0] bytes;
        logic [15:0][31:0]                words;
    } md5_block_u;

    // Byte 0 in the top bits, so %h prints the usual hex string
    typedef logic [0:15][7:0] digest_t;

    typedef struct packed {
        logic                          valid;
        logic [3:0]                    chars;
        logic [MAX_KEY_CHARS-1:0][7:0] value;   // First char in byte 0
    } key_t;

    typedef struct packed {
        logic [2:0]                    digits;
        logic [SUFFIX_DIGITS-1:0][7:0] ascii;   // Most significant digit in byte 0
    } suffix_t;

    localparam logic [31:0] ROUND_K [64] = '{
        32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
        32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
        32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
        32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
        32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
        32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
        32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
        32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
        32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
        32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
        32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
        32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
        32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
        32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
        32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
        32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
    };

    // Four shifts per group, indexed by {group, round mod 4}
    localparam logic [4:0] ROUND_S [16] = '{
        5'd7, 5'd12, 5'd17, 5'd22,
        5'd5, 5'd9,  5'd14, 5'd20,
        5'd4, 5'd11, 5'd16, 5'd23,
        5'd6, 5'd10, 5'd15, 5'd21
    };

    // A, B, C, D
    localparam logic [31:0] MD5_INIT [4] = '{
        32'h67452301, 32'hefcdab89, 32'h98badcfe, 32'h10325476
    };

endpackage

/* logic/tap_decoder.sv */
`timescale 1ns/1ps

module tap_decoder
    import jtag_pkg::*;
(
    input  logic     tck,
    input  logic     reset,
    input  logic     tdi,
    input  logic     test_logic_reset,
    input  logic     ir_is_user,
    input  logic     shift_dr,
    input  logic     update_dr,
    output logic     session_reset,
    output inbound_t inbound
);

    logic [3:0]                            skip_count;
    logic [$clog2(INBOUND_DATA_WIDTH)-1:0] bit_count;
    logic [INBOUND_DATA_WIDTH-1:0]         shift_byte;

    // Any of these ends the current session
    always_ff @(posedge tck) begin
        session_reset <= reset || test_logic_reset || !ir_is_user;
    end

    always_ff @(posedge tck) begin
        if (session_reset) begin
            skip_count     <= '0;
            bit_count      <= '0;
            inbound.strobe <= 1'b0;
        end else begin
            inbound.strobe <= 1'b0;
            if (update_dr) begin
                // Leftover bits of a partial byte are lost here
                skip_count <= '0;
                bit_count  <= '0;
            end else if (shift_dr) begin
                if (skip_count < 4'(UPSTREAM_BYPASS_BITS)) begin
                    skip_count <= skip_count + 4'd1;   // Upstream bypass bit
                end else begin
                    bit_count  <= bit_count + 1'b1;
                    shift_byte <= {tdi, shift_byte[INBOUND_DATA_WIDTH-1:1]};   // LSB first
                    if (&bit_count) begin
                        inbound.strobe <= 1'b1;
                        inbound.data   <= {tdi, shift_byte[INBOUND_DATA_WIDTH-1:1]};
                    end
                end
            end
        end
    end

    // A byte takes eight shifts, so strobes can never touch
    assert property (@(posedge tck) disable iff (session_reset)
        inbound.strobe |=> !inbound.strobe);

endmodule

/* logic/line_decoder.sv */
`timescale 1ns/1ps

module line_decoder
    import jtag_pkg::*;
    import md5_pkg::*;
(
    input  logic     tck,
    input  logic     session_reset,
    input  inbound_t inbound,
    output key_t     key
);

    logic is_newline;
    logic has_room;

    assign is_newline = (inbound.data == 8'h0a);
    assign has_room   = (key.chars < 4'(MAX_KEY_CHARS));

    always_ff @(posedge tck) begin
        if (session_reset) begin
            key.valid <= 1'b0;
            key.chars <= '0;
        end else if (inbound.strobe && !key.valid) begin
            if (is_newline) begin
                key.valid <= 1'b1;   // Key frozen from here on
            end else if (has_room) begin
                key.value[key.chars] <= inbound.data;
                key.chars            <= key.chars + 4'd1;
            end
            // Extra characters past the limit just fall away
        end
    end

endmodule

/* logic/ascii_counter.sv */
`timescale 1ns/1ps

module ascii_counter
    import md5_pkg::*;
(
    input  logic    tck,
    input  logic    session_reset,
    input  logic    suffix_take,
    output suffix_t suffix
);

    logic                          carry;
    logic [SUFFIX_DIGITS-1:0][7:0] next_ascii;
    logic [2:0]                    next_digits;
    logic                          digits_ok;

    // Ripple from the least significant digit toward byte 0
    always_comb begin
        carry       = 1'b1;
        next_ascii  = suffix.ascii;
        next_digits = suffix.digits;
        for (int i = SUFFIX_DIGITS - 1; i >= 0; i--) begin
            if (i < suffix.digits && carry) begin
                if (suffix.ascii[i] == "9") begin
                    next_ascii[i] = "0";
                end else begin
                    next_ascii[i] = suffix.ascii[i] + 8'd1;
                    carry         = 1'b0;
                end
            end
        end
        // All nines: lead with a 1 and widen by one digit
        if (carry && suffix.digits < 3'(SUFFIX_DIGITS)) begin
            next_ascii[0]             = "1";
            next_ascii[suffix.digits] = "0";
            next_digits               = suffix.digits + 3'd1;
        end
    end

    always_ff @(posedge tck) begin
        if (session_reset) begin
            suffix.digits <= 3'd1;
            suffix.ascii  <= {{(SUFFIX_DIGITS - 1){8'h30}}, 8'h31};   // "1"
        end else if (suffix_take) begin
            suffix.digits <= next_digits;
            suffix.ascii  <= next_ascii;
        end
    end

    always_comb begin
        digits_ok = 1'b1;
        for (int i = 0; i < SUFFIX_DIGITS; i++) begin
            if (i < suffix.digits && (suffix.ascii[i] < "0" || suffix.ascii[i] > "9")) begin
                digits_ok = 1'b0;
            end
        end
    end

    assert property (@(posedge tck) disable iff (session_reset) digits_ok);

endmodule

/* logic/block_builder.sv */
`timescale 1ns/1ps

module block_builder
    import md5_pkg::*;
(
    input  logic       tck,
    input  logic       session_reset,
    input  key_t       key,
    input  suffix_t    suffix,
    input  logic       block_ready,
    output logic       block_valid,
    output logic       suffix_take,
    output md5_block_u block
);

    logic [5:0] msg_length;   // Bytes
    md5_block_u next_block;

    assign msg_length  = 6'(key.chars) + 6'(suffix.digits);
    assign suffix_take = block_valid && block_ready;   // Counter steps on each transfer

    always_comb begin
        next_block = '0;
        for (int i = 0; i < MAX_KEY_CHARS; i++) begin
            if (i < key.chars) begin
                next_block.bytes[i] = key.value[i];
            end
        end
        // Suffix follows right after the last key char
        for (int j = 0; j < SUFFIX_DIGITS; j++) begin
            if (j < suffix.digits) begin
                next_block.bytes[6'(key.chars) + 6'(j)] = suffix.ascii[j];
            end
        end
        next_block.bytes[msg_length] = 8'h80;
        // Length in bits, little endian in the last eight bytes
        next_block.bytes[MD5_BLOCK_LENGTH-1 -: 8] = 64'({msg_length, 3'b000});
    end

    always_ff @(posedge tck) begin
        if (session_reset) begin
            block_valid <= 1'b0;
        end else if (block_valid) begin
            if (block_ready) begin
                block_valid <= 1'b0;   // Rebuild next cycle with the new suffix
            end
        end else if (key.valid) begin
            block       <= next_block;
            block_valid <= 1'b1;
        end
    end

    // Offered block must always fit a single MD5 block
    assert property (@(posedge tck) disable iff (session_reset)
        block_valid |-> msg_length <= 6'(MAX_MSG_LENGTH));

endmodule

/* logic/md5_sequencer.sv */
`timescale 1ns/1ps

module md5_sequencer
    import md5_pkg::*;
(
    input  logic       tck,
    input  logic       session_reset,
    input  logic       block_valid,
    input  digest_t    digest,
    output logic       block_ready,
    output logic       load,
    output logic       round_en,
    output logic       finish,
    output logic       found,
    output logic [5:0] round
);

    typedef enum logic [2:0] {IDLE, LOAD, ROUNDS, FINISH, CHECK, DONE} state_t;

    state_t state;
    state_t next_state;
    logic   match;

    assign match    = (digest[0][7:4] == 4'h0);   // First hex char is '0'
    assign load     = (state == LOAD);
    assign round_en = (state == ROUNDS);
    assign finish   = (state == FINISH);

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (block_valid && block_ready) next_state = LOAD;
            LOAD:    next_state = ROUNDS;
            ROUNDS:  if (&round) next_state = FINISH;
            FINISH:  next_state = CHECK;
            CHECK:   next_state = match ? DONE : IDLE;
            DONE:    next_state = DONE;   // Parked until session reset
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge tck) begin
        if (session_reset) begin
            state       <= IDLE;
            round       <= '0;
            block_ready <= 1'b0;
            found       <= 1'b0;
        end else begin
            state       <= next_state;
            block_ready <= (next_state == IDLE);
            found       <= (state == CHECK) && match;
            round       <= (state == ROUNDS) ? round + 6'd1 : 6'd0;
        end
    end

    // Each load gives exactly 64 round cycles, then the final add
    assert property (@(posedge tck) disable iff (session_reset)
        load |=> round_en [*64] ##1 (finish && !round_en));

endmodule

/* logic/md5_datapath.sv */
`timescale 1ns/1ps

module md5_datapath
    import md5_pkg::*;
(
    input  logic       tck,
    input  logic       session_reset,
    input  logic       load,
    input  logic       round_en,
    input  logic       finish,
    input  logic [5:0] round,
    input  md5_block_u block,
    output digest_t    digest
);

    logic [31:0] a, b, c, d;
    md5_block_u  block_q;
    logic [31:0] f;
    logic [3:0]  g;            // Message word index
    logic [31:0] sum;
    logic [63:0] rot_full;
    logic [31:0] rotated;

    function automatic logic [31:0] byte_swap(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    always_comb begin
        case (round[5:4])
            2'd0: begin
                f = (b & c) | (~b & d);
                g = round[3:0];
            end
            2'd1: begin
                f = (d & b) | (~d & c);
                g = round[3:0] * 4'd5 + 4'd1;
            end
            2'd2: begin
                f = b ^ c ^ d;
                g = round[3:0] * 4'd3 + 4'd5;
            end
            default: begin
                f = c ^ (b | ~d);
                g = round[3:0] * 4'd7;
            end
        endcase
        sum      = a + f + ROUND_K[round] + block_q.words[g];
        rot_full = {sum, sum} << ROUND_S[{round[5:4], round[1:0]}];
        rotated  = rot_full[63:32];   // Left rotate
    end

    always_ff @(posedge tck) begin
        if (load) begin
            block_q <= block;
            a       <= MD5_INIT[0];
            b       <= MD5_INIT[1];
            c       <= MD5_INIT[2];
            d       <= MD5_INIT[3];
        end else if (round_en) begin
            a <= d;
            d <= c;
            c <= b;
            b <= b + rotated;
        end
    end

    // Single block, so the chaining values are the initial state
    // Words go out low byte first
    always_ff @(posedge tck) begin
        if (session_reset) begin
            digest <= '0;
        end else if (finish) begin
            digest <= {byte_swap(a + MD5_INIT[0]), byte_swap(b + MD5_INIT[1]),
                       byte_swap(c + MD5_INIT[2]), byte_swap(d + MD5_INIT[3])};
        end
    end

endmodule

/* logic/tap_encoder.sv */
`timescale 1ns/1ps

module tap_encoder
    import jtag_pkg::*;
    import md5_pkg::*;
(
    input  logic    tck,
    input  logic    session_reset,
    input  logic    found,
    input  digest_t digest,
    input  logic    capture_dr,
    input  logic    shift_dr,
    output logic    tdo
);

    result_t                 held;
    logic [RESULT_WIDTH-1:0] shift_reg;

    always_ff @(posedge tck) begin
        if (session_reset) begin
            held <= '0;
        end else if (found && !held.found) begin
            held.digest <= digest;   // First match wins
            held.found  <= 1'b1;
        end
    end

    always_ff @(posedge tck) begin
        if (session_reset) begin
            shift_reg <= '0;
        end else if (capture_dr) begin
            shift_reg <= held;
        end else if (shift_dr) begin
            shift_reg <= {1'b0, shift_reg[RESULT_WIDTH-1:1]};
        end
    end

    assign tdo = shift_reg[0];

endmodule

/* logic/user_logic.sv */
`timescale 1ns/1ps

module user_logic
    import jtag_pkg::*;
    import md5_pkg::*;
(
    input  logic tck,
    input  logic reset,
    input  logic tdi,
    input  logic test_logic_reset,
    input  logic ir_is_user,
    input  logic capture_dr,
    input  logic shift_dr,
    input  logic update_dr,
    output logic tdo
);

    logic       session_reset;
    inbound_t   inbound;
    key_t       key;
    suffix_t    suffix;
    logic       suffix_take;
    md5_block_u block;
    logic       block_valid;
    logic       block_ready;
    logic       load;
    logic       round_en;
    logic       finish;
    logic [5:0] round;
    digest_t    digest;
    logic       found;

    tap_decoder tap_decoder_i (
        .tck              (tck),
        .reset            (reset),
        .tdi              (tdi),
        .test_logic_reset (test_logic_reset),
        .ir_is_user       (ir_is_user),
        .shift_dr         (shift_dr),
        .update_dr        (update_dr),
        .session_reset    (session_reset),
        .inbound          (inbound)
    );

    line_decoder line_decoder_i (
        .tck           (tck),
        .session_reset (session_reset),
        .inbound       (inbound),
        .key           (key)
    );

    ascii_counter ascii_counter_i (
        .tck           (tck),
        .session_reset (session_reset),
        .suffix_take   (suffix_take),
        .suffix        (suffix)
    );

    block_builder block_builder_i (
        .tck           (tck),
        .session_reset (session_reset),
        .key           (key),
        .suffix        (suffix),
        .block_ready   (block_ready),
        .block_valid   (block_valid),
        .suffix_take   (suffix_take),
        .block         (block)
    );

    md5_sequencer md5_sequencer_i (
        .tck           (tck),
        .session_reset (session_reset),
        .block_valid   (block_valid),
        .digest        (digest),
        .block_ready   (block_ready),
        .load          (load),
        .round_en      (round_en),
        .finish        (finish),
        .found         (found),
        .round         (round)
    );

    md5_datapath md5_datapath_i (
        .tck           (tck),
        .session_reset (session_reset),
        .load          (load),
        .round_en      (round_en),
        .finish        (finish),
        .round         (round),
        .block         (block),
        .digest        (digest)
    );

    tap_encoder tap_encoder_i (
        .tck           (tck),
        .session_reset (session_reset),
        .found         (found),
        .digest        (digest),
        .capture_dr    (capture_dr),
        .shift_dr      (shift_dr),
        .tdo           (tdo)
    );

endmodule

/* sim/md5_ref.svh */
`ifndef MD5_REF_SVH
`define MD5_REF_SVH

// Round constant from the sine table, floor(|sin(i + 1)| * 2^32)
function automatic logic [31:0] sine_const(input int i);
    real         s;
    logic [63:0] wide;
    s = $sin(i + 1);
    if (s < 0.0) begin
        s = -s;
    end
    wide = longint'($floor(s * 4294967296.0));
    return wide[31:0];
endfunction

function automatic int shift_amount(input int i);
    int table_s [4][4] = '{'{7, 12, 17, 22}, '{5, 9, 14, 20},
                           '{4, 11, 16, 23}, '{6, 10, 15, 21}};
    return table_s[i / 16][i % 4];
endfunction

function automatic logic [31:0] rotl(input logic [31:0] x, input int n);
    return (x << n) | (x >> (32 - n));
endfunction

function automatic logic [31:0] le_word(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};   // Low byte printed first
endfunction

// Plain MD5 of a byte string, result with byte 0 in the top bits
function automatic logic [127:0] md5_of(input byte unsigned msg[$]);
    byte unsigned padded[$];
    logic [31:0]  m [16];
    logic [31:0]  h0, h1, h2, h3;
    logic [31:0]  a, b, c, d, f, t;
    logic [63:0]  bit_len;
    int           g;
    padded  = msg;
    bit_len = 64'(msg.size()) * 64'd8;
    padded.push_back(8'h80);
    while (padded.size() % 64 != 56) begin
        padded.push_back(8'h00);
    end
    for (int i = 0; i < 8; i++) begin
        padded.push_back(bit_len[8*i +: 8]);
    end
    h0 = 32'h67452301;
    h1 = 32'hefcdab89;
    h2 = 32'h98badcfe;
    h3 = 32'h10325476;
    for (int base = 0; base < padded.size(); base += 64) begin
        for (int w = 0; w < 16; w++) begin
            m[w] = {padded[base + 4*w + 3], padded[base + 4*w + 2],
                    padded[base + 4*w + 1], padded[base + 4*w]};
        end
        a = h0;
        b = h1;
        c = h2;
        d = h3;
        for (int i = 0; i < 64; i++) begin
            case (i / 16)
                0: begin
                    f = (b & c) | (~b & d);
                    g = i;
                end
                1: begin
                    f = (d & b) | (~d & c);
                    g = (5 * i + 1) % 16;
                end
                2: begin
                    f = b ^ c ^ d;
                    g = (3 * i + 5) % 16;
                end
                default: begin
                    f = c ^ (b | ~d);
                    g = (7 * i) % 16;
                end
            endcase
            t = a + f + sine_const(i) + m[g];
            a = d;
            d = c;
            c = b;
            b = b + rotl(t, shift_amount(i));
        end
        h0 += a;
        h1 += b;
        h2 += c;
        h3 += d;
    end
    return {le_word(h0), le_word(h1), le_word(h2), le_word(h3)};
endfunction

// Tries prefix + "1", "2", ... until the first hex char of the digest is 0
function automatic logic [127:0] search_suffix(input byte unsigned prefix[$], output int tries);
    byte unsigned msg[$];
    string        digits;
    logic [127:0] d;
    d     = '0;
    tries = 0;
    for (int n = 1; n <= 9999999; n++) begin
        msg    = prefix;
        digits = $sformatf("%0d", n);
        for (int k = 0; k < digits.len(); k++) begin
            msg.push_back(digits[k]);
        end
        d = md5_of(msg);
        if (d[127:124] == 4'h0) begin
            tries = n;
            return d;
        end
    end
    return d;
endfunction

`endif

/* sim/tb_user_logic.sv */
`timescale 1ns/1ps

module tb_user_logic;

    localparam int NUM_KEYS    = 10;
    localparam int CYCLE_LIMIT = NUM_KEYS * (40 * 68 + 1024) + 512;   // Searches plus shifting

    logic tck;
    logic reset;
    logic tdi;
    logic test_logic_reset;
    logic ir_is_user;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic tdo;

    int           seed           = 32'h3a25_25f6;
    int           cycle_count    = 0;
    int           check_count    = 0;
    int           error_count    = 0;
    int           two_digit_runs = 0;

    `include "md5_ref.svh"

    user_logic dut_i (
        .tck              (tck),
        .reset            (reset),
        .tdi              (tdi),
        .test_logic_reset (test_logic_reset),
        .ir_is_user       (ir_is_user),
        .capture_dr       (capture_dr),
        .shift_dr         (shift_dr),
        .update_dr        (update_dr),
        .tdo              (tdo)
    );

    initial begin
        tck = 1'b0;
        forever #2 tck = ~tck;
    end

    always @(posedge tck) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the search never finished", cycle_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    function automatic int random_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic pulse_update();
        update_dr = 1'b1;
        @(negedge tck);
        update_dr = 1'b0;
    endtask

    task automatic shift_in_byte(input logic [7:0] value);
        for (int i = 0; i < 8; i++) begin
            tdi      = value[i];   // LSB first
            shift_dr = 1'b1;
            @(negedge tck);
        end
    endtask

    // Leading bit is eaten by the upstream device in bypass
    task automatic send_line(input byte unsigned chars[$]);
        tdi      = 1'b0;
        shift_dr = 1'b1;
        @(negedge tck);
        foreach (chars[i]) begin
            shift_in_byte(chars[i]);
        end
        shift_dr = 1'b0;
        pulse_update();
    endtask

    task automatic send_stray_bits();
        for (int i = 0; i < 5; i++) begin
            tdi      = 1'(random_below(2));
            shift_dr = 1'b1;
            @(negedge tck);
        end
        shift_dr = 1'b0;
        pulse_update();   // Partial byte dropped here
    endtask

    task automatic capture_flag(output logic flag);
        capture_dr = 1'b1;
        @(negedge tck);
        capture_dr = 1'b0;
        flag = tdo;
    endtask

    task automatic read_digest(output logic [127:0] value);
        for (int i = 0; i < 128; i++) begin
            tdi      = 1'b0;
            shift_dr = 1'b1;
            @(negedge tck);
            value[i] = tdo;
        end
        shift_dr = 1'b0;
    endtask

    task automatic restart_session();
        ir_is_user = 1'b0;
        repeat (2) @(negedge tck);
        ir_is_user = 1'b1;
        repeat (2) @(negedge tck);
    endtask

    task automatic run_key(input int index);
        byte unsigned typed[$];
        byte unsigned hashed[$];
        int           length;
        int           extra;
        int           tries;
        logic         flag;
        logic [127:0] expected;
        logic [127:0] actual;
        length = 1 + random_below(12);
        if (index % 3 == 2) begin
            length = 13 + random_below(3);   // Runs past the key limit
        end
        for (int i = 0; i < length; i++) begin
            typed.push_back(8'(97 + random_below(26)));
            if (i < 12) begin
                hashed.push_back(typed[i]);
            end
        end
        typed.push_back(8'h0a);
        extra = random_below(4);
        for (int i = 0; i < extra; i++) begin
            typed.push_back(8'(97 + random_below(26)));   // After the newline
        end
        expected = search_suffix(hashed, tries);
        if (tries >= 10) begin
            two_digit_runs++;
        end
        restart_session();
        // Previous match must be gone once the session restarts
        capture_flag(flag);
        check_equal(128'(flag), 128'd0,
                    $sformatf("found flag before key %0d after session restart", index));
        if (index % 2 == 1) begin
            send_stray_bits();
        end
        send_line(typed);
        flag = 1'b0;
        while (!flag) begin
            repeat (32) @(negedge tck);
            capture_flag(flag);
        end
        read_digest(actual);
        check_equal(actual, expected,
                    $sformatf("digest of key %0d after %0d tries", index, tries));
    endtask

    initial begin
        logic         flag;
        logic [127:0] value;
        reset            = 1'b1;
        tdi              = 1'b0;
        test_logic_reset = 1'b0;
        ir_is_user       = 1'b1;
        capture_dr       = 1'b0;
        shift_dr         = 1'b0;
        update_dr        = 1'b0;
        repeat (3) @(negedge tck);
        reset = 1'b0;
        repeat (2) @(negedge tck);

        capture_flag(flag);
        read_digest(value);
        check_equal(128'(flag), 128'd0, "found flag after reset");
        check_equal(value, 128'd0, "digest after reset");

        for (int k = 0; k < NUM_KEYS; k++) begin
            run_key(k);
        end
        check_equal(128'(two_digit_runs > 0), 128'd1, "no search ran past suffix 9");

        $display("Checks: %0d, errors: %0d, two-digit searches: %0d",
                 check_count, error_count, two_digit_runs);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+sim
logic/jtag_pkg.sv
logic/md5_pkg.sv
logic/tap_decoder.sv
logic/line_decoder.sv
logic/ascii_counter.sv
logic/block_builder.sv
logic/md5_sequencer.sv
logic/md5_datapath.sv
logic/tap_encoder.sv
logic/user_logic.sv
sim/tb_user_logic.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then judge the run by its log
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal -f sources.f --top-module tb_user_logic \
    -o tb_user_logic > build.log 2>&1 \
    && ./obj_dir/tb_user_logic > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "Simulation failed"; exit 1; } || echo "Simulation passed"
